// File: logic/acq_settings.svh
`ifndef ACQ_SETTINGS_SVH
`define ACQ_SETTINGS_SVH

// ------------------------------------------------------------
// sampling front end sizes

`define ACQ_SAMPLE_W    12   // AD9434 sample bits
`define ACQ_CAPTURE_LEN 16   // words per channel per trigger
`define ACQ_NUM_CHAN    2    // capture channels

// ------------------------------------------------------------
// pulse generator field widths

`define ACQ_WIDTH_W     11   // pulse width and pulse count
`define ACQ_GAP_W       16   // gap between pulses, in cycles

`endif

// File: logic/acq_pkg.sv
`default_nettype none
`include "acq_settings.svh"

package acq_pkg;

    // one captured word, overrange flag on top
    typedef struct packed {
        logic                     ovr;   // ADC overrange
        logic [`ACQ_SAMPLE_W-1:0] data;  // raw sample
    } sample_t;

    typedef logic [$clog2(`ACQ_CAPTURE_LEN)-1:0] buf_addr_t;  // buffer index
    typedef logic [$clog2(`ACQ_NUM_CHAN)-1:0]    chan_idx_t;  // channel index

    typedef enum logic [1:0] {IDLE, HIGH, GAP} pulse_state_e;

    typedef enum logic [1:0] {ARMED, FILL, FULL} capture_state_e;

    typedef enum logic [1:0] {WAIT_FULL, DRAIN, RELEASE} readout_state_e;

endpackage

`default_nettype wire

// File: logic/capture_if.sv
`timescale 1ns/1ps
`default_nettype none

interface capture_if;
    import acq_pkg::*;

    logic      full;         // buffer holds a complete capture
    buf_addr_t rd_addr;      // word select from readout
    sample_t   rd_data;      // registered word, one cycle after rd_addr
    logic      release_stb;  // one cycle, frees the buffer

    // channel end
    modport capture_side (
        output full,
        output rd_data,
        input  rd_addr,
        input  release_stb
    );

    // readout end
    modport readout_side (
        input  full,
        input  rd_data,
        output rd_addr,
        output release_stb
    );

endinterface

`default_nettype wire

// File: logic/pulse_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module pulse_gen (
    input  wire                    clk_200m,
    input  wire                    i_reset,
    input  wire                    i_start,
    input  wire [`ACQ_WIDTH_W-1:0] i_pulse_width,  // high cycles per pulse
    input  wire [`ACQ_WIDTH_W-1:0] i_pulse_num,    // pulses per train
    input  wire [`ACQ_GAP_W-1:0]   i_gap_cycles,   // low cycles between pulses
    output logic                   o_pulse,
    output logic                   o_trig,
    output logic                   o_done
);
    import acq_pkg::*;

    localparam int CNT_W = (`ACQ_GAP_W > `ACQ_WIDTH_W) ? `ACQ_GAP_W : `ACQ_WIDTH_W;

    pulse_state_e            state;
    logic [CNT_W-1:0]        cnt;          // cycles left in this phase, minus one
    logic [`ACQ_WIDTH_W-1:0] pulses_left;  // pulses still to go after this one
    logic [`ACQ_WIDTH_W-1:0] width_r;      // latched width
    logic [`ACQ_GAP_W-1:0]   gap_r;        // latched gap
    logic                    cnt_zero;
    logic                    last_pulse;

    assign cnt_zero   = (cnt == '0);
    assign last_pulse = (pulses_left == '0);
    assign o_pulse    = (state == HIGH);  // pulse follows the state directly

    // ------------------------------------------------------------
    // settings, held for the whole train

    always_ff @(posedge clk_200m) begin
        if (state == IDLE && i_start) begin
            width_r <= i_pulse_width;
            gap_r   <= i_gap_cycles;
        end
    end

    // ------------------------------------------------------------
    // train sequencing

    always_ff @(posedge clk_200m) begin
        if (i_reset) begin
            state       <= IDLE;
            cnt         <= '0;
            pulses_left <= '0;
            o_trig      <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            o_trig <= 1'b0;  // strobes
            o_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_start) begin
                        if (i_pulse_width == '0 || i_pulse_num == '0) begin
                            o_done <= 1'b1;  // empty train, finish at once
                        end else begin
                            state       <= HIGH;
                            o_trig      <= 1'b1;  // with first high cycle
                            cnt         <= CNT_W'(i_pulse_width - 1'b1);
                            pulses_left <= i_pulse_num - 1'b1;
                        end
                    end
                end
                HIGH: begin
                    if (!cnt_zero) begin
                        cnt <= cnt - 1'b1;
                    end else if (last_pulse) begin
                        state  <= IDLE;
                        o_done <= 1'b1;  // lands in first low cycle
                    end else if (gap_r == '0) begin
                        cnt         <= CNT_W'(width_r - 1'b1);  // back to back
                        pulses_left <= pulses_left - 1'b1;
                    end else begin
                        state       <= GAP;
                        cnt         <= CNT_W'(gap_r - 1'b1);
                        pulses_left <= pulses_left - 1'b1;
                    end
                end
                GAP: begin
                    if (cnt_zero) begin
                        state <= HIGH;
                        cnt   <= CNT_W'(width_r - 1'b1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // trigger only ever marks the rising edge of a train
    a_trig_on_rise: assert property (@(posedge clk_200m) disable iff (i_reset)
        o_trig |-> $rose(o_pulse));

endmodule

`default_nettype wire

// File: logic/adc_capture.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module adc_capture (
    input  wire                     clk_200m,
    input  wire                     i_reset,
    input  wire                     i_trig,      // from pulse_gen
    input  wire [`ACQ_SAMPLE_W-1:0] i_adc_data,  // parallel ADC word
    input  wire                     i_adc_or,    // overrange pin
    capture_if.capture_side         cap
);
    import acq_pkg::*;

    localparam int LEN = `ACQ_CAPTURE_LEN;
    localparam buf_addr_t LAST_ADDR = buf_addr_t'(LEN - 1);

    capture_state_e state;
    buf_addr_t      wr_addr;    // next word to write
    sample_t        adc_q;      // input register
    sample_t        mem [LEN];  // capture buffer

    // ------------------------------------------------------------
    // free running input register

    always_ff @(posedge clk_200m) begin
        adc_q.ovr  <= i_adc_or;
        adc_q.data <= i_adc_data;
    end

    // ------------------------------------------------------------
    // arm / fill / hold

    always_ff @(posedge clk_200m) begin
        if (i_reset) begin
            state   <= ARMED;
            wr_addr <= '0;
        end else begin
            case (state)
                ARMED: begin
                    if (i_trig) begin  // triggers elsewhere are dropped
                        state   <= FILL;
                        wr_addr <= '0;
                    end
                end
                FILL: begin
                    wr_addr <= wr_addr + 1'b1;
                    if (wr_addr == LAST_ADDR) begin
                        state <= FULL;
                    end
                end
                FULL: begin
                    if (cap.release_stb) begin
                        state <= ARMED;  // readout done with us
                    end
                end
                default: state <= ARMED;
            endcase
        end
    end

    // buffer write and registered read port
    always_ff @(posedge clk_200m) begin
        if (state == FILL) begin
            mem[wr_addr] <= adc_q;  // word 0 is the trig-cycle sample
        end
        cap.rd_data <= mem[cap.rd_addr];
    end

    assign cap.full = (state == FULL);

    // an accepted trigger gives exactly LEN fill cycles before full
    a_fill_len: assert property (@(posedge clk_200m) disable iff (i_reset)
        (state == ARMED && i_trig) |=> (state == FILL) [*LEN] ##1 cap.full);

endmodule

`default_nettype wire

// File: logic/capture_readout.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module capture_readout (
    input  wire                clk_200m,
    input  wire                i_reset,
    capture_if.readout_side    caps [`ACQ_NUM_CHAN],
    output logic               o_rd_valid,
    output acq_pkg::chan_idx_t o_rd_chan,
    output acq_pkg::sample_t   o_rd_sample,
    output logic               o_rd_last
);
    import acq_pkg::*;

    localparam int NCH = `ACQ_NUM_CHAN;
    localparam buf_addr_t LAST_ADDR = buf_addr_t'(`ACQ_CAPTURE_LEN - 1);
    localparam chan_idx_t LAST_CHAN = chan_idx_t'(NCH - 1);

    readout_state_e state;
    chan_idx_t      chan;        // channel being addressed
    buf_addr_t      addr;        // word being addressed
    logic [NCH-1:0] full_vec;
    sample_t        words [NCH];  // registered words from each channel
    logic           all_full;
    logic           end_of_drain;
    logic           rel;

    // ------------------------------------------------------------
    // per channel fan in / fan out

    for (genvar g = 0; g < NCH; g++) begin : g_chan
        assign full_vec[g]         = caps[g].full;
        assign words[g]            = caps[g].rd_data;
        assign caps[g].rd_addr     = addr;  // same address to all
        assign caps[g].release_stb = rel;
    end

    assign all_full     = &full_vec;
    assign end_of_drain = (state == DRAIN) && (addr == LAST_ADDR) && (chan == LAST_CHAN);
    assign rel          = (state == RELEASE) && !o_rd_valid;  // after last word left

    // ------------------------------------------------------------
    // drain sequencing

    always_ff @(posedge clk_200m) begin
        if (i_reset) begin
            state <= WAIT_FULL;
            chan  <= '0;
            addr  <= '0;
        end else begin
            case (state)
                WAIT_FULL: begin
                    if (all_full) begin
                        state <= DRAIN;
                        chan  <= '0;
                        addr  <= '0;
                    end
                end
                DRAIN: begin
                    addr <= addr + 1'b1;  // wraps to 0 per channel
                    if (addr == LAST_ADDR) begin
                        if (chan == LAST_CHAN) begin
                            state <= RELEASE;
                        end else begin
                            chan <= chan + 1'b1;
                        end
                    end
                end
                RELEASE: begin
                    if (rel) begin
                        state <= WAIT_FULL;
                    end
                end
                default: state <= WAIT_FULL;
            endcase
        end
    end

    // output flags, one cycle behind the address
    always_ff @(posedge clk_200m) begin
        if (i_reset) begin
            o_rd_valid <= 1'b0;
            o_rd_last  <= 1'b0;
        end else begin
            o_rd_valid <= (state == DRAIN);
            o_rd_last  <= end_of_drain;
        end
    end

    always_ff @(posedge clk_200m) begin
        o_rd_chan <= chan;  // tags the returning word
    end

    assign o_rd_sample = words[o_rd_chan];

    // release only on full buffers, and every channel drops full right after
    a_release_full: assert property (@(posedge clk_200m) disable iff (i_reset)
        rel |-> all_full ##1 (full_vec == '0));

endmodule

`default_nettype wire

// File: logic/acq_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module acq_top (
    input  wire                     clk_200m,
    input  wire                     i_reset,
    // pulse generator control
    input  wire                     i_start,
    input  wire [`ACQ_WIDTH_W-1:0]  i_pulse_width,
    input  wire [`ACQ_WIDTH_W-1:0]  i_pulse_num,
    input  wire [`ACQ_GAP_W-1:0]    i_gap_cycles,
    // ADC0
    input  wire [`ACQ_SAMPLE_W-1:0] i_adc0_data,
    input  wire                     i_adc0_or,
    // ADC1
    input  wire [`ACQ_SAMPLE_W-1:0] i_adc1_data,
    input  wire                     i_adc1_or,
    // pulse outputs
    output logic                    o_pulse,
    output logic                    o_trig,
    output logic                    o_done,
    // readout stream
    output logic                    o_rd_valid,
    output acq_pkg::chan_idx_t      o_rd_chan,
    output acq_pkg::sample_t        o_rd_sample,
    output logic                    o_rd_last
);
    import acq_pkg::*;

    logic [`ACQ_SAMPLE_W-1:0] adc_data [`ACQ_NUM_CHAN];  // per channel samples
    logic                     adc_or   [`ACQ_NUM_CHAN];  // per channel overrange

    capture_if caps [`ACQ_NUM_CHAN] ();  // channel <-> readout

    assign adc_data[0] = i_adc0_data;
    assign adc_or[0]   = i_adc0_or;
    assign adc_data[1] = i_adc1_data;
    assign adc_or[1]   = i_adc1_or;

    // ------------------------------------------------------------
    // pulse generator

    pulse_gen pulse_gen_inst (
        .clk_200m      (clk_200m),
        .i_reset       (i_reset),
        .i_start       (i_start),
        .i_pulse_width (i_pulse_width),
        .i_pulse_num   (i_pulse_num),
        .i_gap_cycles  (i_gap_cycles),
        .o_pulse       (o_pulse),
        .o_trig        (o_trig),
        .o_done        (o_done)
    );

    // ------------------------------------------------------------
    // ADC capture channels

    for (genvar ch = 0; ch < `ACQ_NUM_CHAN; ch++) begin : g_adc
        adc_capture adc_capture_inst (
            .clk_200m   (clk_200m),
            .i_reset    (i_reset),
            .i_trig     (o_trig),  // same trigger to every channel
            .i_adc_data (adc_data[ch]),
            .i_adc_or   (adc_or[ch]),
            .cap        (caps[ch])
        );
    end

    // ------------------------------------------------------------
    // readout

    capture_readout capture_readout_inst (
        .clk_200m    (clk_200m),
        .i_reset     (i_reset),
        .caps        (caps),
        .o_rd_valid  (o_rd_valid),
        .o_rd_chan   (o_rd_chan),
        .o_rd_sample (o_rd_sample),
        .o_rd_last   (o_rd_last)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 4.0  // 250 MHz stand-in for clk_200m
) (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #(PERIOD_NS / 2.0) o_clk = ~o_clk;  // half period per phase

endmodule

`default_nettype wire

// File: tests/acq_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module acq_tb;
    import acq_pkg::*;

    localparam int LEN        = `ACQ_CAPTURE_LEN;
    localparam int NUM_WORDS  = `ACQ_NUM_CHAN * LEN;  // words per readout
    localparam int NUM_TRAINS = 6;                    // random trains after the empty one
    localparam int MAX_W      = 6;
    localparam int MAX_N      = 4;
    localparam int MAX_G      = 5;
    localparam int HIST_N     = 4096;                 // depth of driven-input history
    localparam int TRAIN_CYC  = MAX_N * MAX_W + (MAX_N - 1) * MAX_G + 8;
    localparam int READ_CYC   = LEN + NUM_WORDS + 8;  // fill plus drain plus re-arm
    localparam int WATCHDOG_CYCLES = 2 * (40 + (NUM_TRAINS + 1) * (TRAIN_CYC + READ_CYC));

    typedef logic [`ACQ_WIDTH_W-1:0] width_t;
    typedef logic [`ACQ_GAP_W-1:0]   gap_t;

    logic                     clk_200m;
    logic                     i_reset;
    logic                     i_start;
    width_t                   i_pulse_width;
    width_t                   i_pulse_num;
    gap_t                     i_gap_cycles;
    logic [`ACQ_SAMPLE_W-1:0] i_adc0_data;
    logic                     i_adc0_or;
    logic [`ACQ_SAMPLE_W-1:0] i_adc1_data;
    logic                     i_adc1_or;
    logic                     o_pulse;
    logic                     o_trig;
    logic                     o_done;
    logic                     o_rd_valid;
    chan_idx_t                o_rd_chan;
    sample_t                  o_rd_sample;
    logic                     o_rd_last;

    int   value_errors = 0;
    int   other_errors = 0;
    int   cyc          = 0;     // cycle number used as history index
    logic rst_seen     = 1'b0;
    logic started      = 1'b0;  // first start sampled

    sample_t hist [`ACQ_NUM_CHAN][HIST_N];  // every driven ADC word

    // pulse model tracks position since the accepted start
    logic m_busy;
    logic m_empty_done;
    int   m_t;
    int   m_w;
    int   m_n;
    int   m_g;
    int   m_total;  // cycle of the done strobe
    logic m_live;
    logic exp_pulse;
    logic exp_trig;
    logic exp_done;

    // readout model
    int        rd_idx;      // word number within the stream
    int        cap_base;    // history index of the trig cycle
    logic      pending;     // a capture waits to be read
    int        trig_count;
    int        words_read;
    chan_idx_t exp_chan;
    sample_t   exp_sample;

    tb_clock #(.PERIOD_NS(4.0)) clk_gen (.o_clk(clk_200m));

    acq_top DUT (.*);  // port names match one to one

    task automatic count_value_error(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
        value_errors++;
        $display("mismatch %s: got %h, expected %h", name, got, exp);
    endtask

    task automatic log_failure(input string what);
        other_errors++;
        $display("%s", what);
    endtask

    // ------------------------------------------------------------
    // stimulus

    // free running ADC counters and random overrange
    always @(posedge clk_200m) begin
        i_adc0_data <= i_adc0_data + 1'b1;
        i_adc1_data <= i_adc1_data + 1'b1;
        i_adc0_or   <= ($urandom % 2) == 1;
        i_adc1_or   <= ($urandom % 2) == 1;
    end

    task automatic run_train(input width_t width, input width_t num, input gap_t gap);
        logic got_done;
        logic got_last;
        got_done = 1'b0;
        got_last = (width == '0 || num == '0);  // nothing to read after an empty train
        @(posedge clk_200m);
        i_pulse_width <= width;
        i_pulse_num   <= num;
        i_gap_cycles  <= gap;
        i_start       <= 1'b1;
        @(posedge clk_200m);
        if (!got_last) begin
            @(posedge clk_200m);  // start held into the first high cycle
        end
        i_start <= 1'b0;
        while (!(got_done && got_last)) begin
            @(posedge clk_200m);
            got_done = got_done || o_done;
            got_last = got_last || o_rd_last;
        end
        repeat (4) @(posedge clk_200m);  // release and re-arm
    endtask

    initial begin
        void'($urandom(32'h39fd_4359));  // seeds the generator
        i_reset       = 1'b1;
        i_start       = 1'b0;
        i_pulse_width = '0;
        i_pulse_num   = '0;
        i_gap_cycles  = '0;
        i_adc0_data   = 12'h100;  // distinct offsets per channel
        i_adc1_data   = 12'ha00;
        i_adc0_or     = 1'b0;
        i_adc1_or     = 1'b0;
        repeat (16) @(posedge clk_200m);
        i_reset <= 1'b0;
        repeat (4) @(posedge clk_200m);
        run_train(width_t'(0), width_t'(3), gap_t'(2));  // zero width gives only done
        for (int n = 0; n < NUM_TRAINS; n++) begin
            run_train(width_t'(1 + $urandom % MAX_W), width_t'(1 + $urandom % MAX_N),
                      gap_t'(1 + $urandom % MAX_G));
        end
        repeat (8) @(posedge clk_200m);
        a_trig_count: assert (trig_count == NUM_TRAINS)
            else log_failure($sformatf("saw %0d triggers instead of %0d",
                                       trig_count, NUM_TRAINS));
        a_word_count: assert (words_read == NUM_TRAINS * NUM_WORDS)
            else log_failure($sformatf("read %0d words instead of %0d",
                                       words_read, NUM_TRAINS * NUM_WORDS));
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_200m);
        $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // reference model

    always @(posedge clk_200m) begin
        cyc <= cyc + 1;
        hist[0][cyc % HIST_N] <= {i_adc0_or, i_adc0_data};  // value of the cycle just ended
        hist[1][cyc % HIST_N] <= {i_adc1_or, i_adc1_data};
        if (i_reset) rst_seen <= 1'b1;
        if (i_start) started <= 1'b1;
    end

    assign m_total   = m_n * m_w + (m_n - 1) * m_g;
    assign m_live    = m_busy && (m_t < m_total);
    assign exp_pulse = m_live && ((m_t % (m_w + m_g)) < m_w);  // high part of each period
    assign exp_trig  = m_busy && (m_t == 0);
    assign exp_done  = (m_busy && m_t == m_total) || m_empty_done;

    always @(posedge clk_200m) begin
        if (i_reset) begin
            m_busy       <= 1'b0;
            m_empty_done <= 1'b0;
            m_t          <= 0;
            m_w          <= 1;  // keeps the period nonzero
            m_n          <= 1;
            m_g          <= 0;
        end else begin
            m_empty_done <= 1'b0;
            if (!m_live && i_start) begin
                if (i_pulse_width == '0 || i_pulse_num == '0) begin
                    m_busy       <= 1'b0;
                    m_empty_done <= 1'b1;
                end else begin
                    m_busy <= 1'b1;
                    m_t    <= 0;
                    m_w    <= int'(i_pulse_width);
                    m_n    <= int'(i_pulse_num);
                    m_g    <= int'(i_gap_cycles);
                end
            end else if (m_busy) begin
                if (m_t == m_total) m_busy <= 1'b0;
                else m_t <= m_t + 1;
            end
        end
    end

    assign exp_chan   = chan_idx_t'(rd_idx / LEN);
    assign exp_sample = hist[rd_idx / LEN][(cap_base + rd_idx % LEN) % HIST_N];

    always @(posedge clk_200m) begin
        if (i_reset) begin
            rd_idx     <= 0;
            pending    <= 1'b0;
            trig_count <= 0;
            words_read <= 0;
        end else begin
            if (o_trig) begin
                cap_base   <= cyc;  // word 0 is the trig-cycle input
                pending    <= 1'b1;
                trig_count <= trig_count + 1;
            end
            if (o_rd_valid) begin
                words_read <= words_read + 1;
                if (rd_idx == NUM_WORDS - 1) begin
                    rd_idx  <= 0;
                    pending <= 1'b0;
                end else begin
                    rd_idx <= rd_idx + 1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // checks

    a_quiet: assert property (@(posedge clk_200m) (rst_seen && !started)
        |-> !(o_pulse || o_trig || o_done || o_rd_valid))
        else log_failure("outputs active after reset before any start");

    a_pulse: assert property (@(posedge clk_200m) disable iff (i_reset) o_pulse == exp_pulse)
        else count_value_error("o_pulse", $sampled(o_pulse), $sampled(exp_pulse));

    a_trig: assert property (@(posedge clk_200m) disable iff (i_reset) o_trig == exp_trig)
        else count_value_error("o_trig", $sampled(o_trig), $sampled(exp_trig));

    a_done: assert property (@(posedge clk_200m) disable iff (i_reset) o_done == exp_done)
        else count_value_error("o_done", $sampled(o_done), $sampled(exp_done));

    a_rd_pending: assert property (@(posedge clk_200m) disable iff (i_reset)
        o_rd_valid |-> pending)
        else log_failure("readout word with no captured trigger");

    a_rd_chan: assert property (@(posedge clk_200m) disable iff (i_reset)
        o_rd_valid |-> o_rd_chan == exp_chan)
        else count_value_error("o_rd_chan", $sampled(o_rd_chan), $sampled(exp_chan));

    a_rd_sample: assert property (@(posedge clk_200m) disable iff (i_reset)
        o_rd_valid |-> o_rd_sample == exp_sample)
        else count_value_error("o_rd_sample", $sampled(o_rd_sample), $sampled(exp_sample));

    // last flag only with word 32
    a_rd_last: assert property (@(posedge clk_200m) disable iff (i_reset)
        o_rd_last == (o_rd_valid && rd_idx == NUM_WORDS - 1))
        else count_value_error("o_rd_last", $sampled(o_rd_last),
                               $sampled(o_rd_valid && rd_idx == NUM_WORDS - 1));

    a_rd_run: assert property (@(posedge clk_200m) disable iff (i_reset)
        (o_rd_valid && rd_idx != NUM_WORDS - 1) |=> o_rd_valid)
        else log_failure("readout stream stopped before its last word");

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
logic/acq_pkg.sv
logic/capture_if.sv
logic/pulse_gen.sv
logic/adc_capture.sv
logic/capture_readout.sv
logic/acq_top.sv
tests/tb_clock.sv
tests/acq_tb.sv

// File: Makefile
SOURCES := $(filter-out +%,$(shell cat filelist.f)) logic/acq_settings.svh

all: run

obj_dir/Vacq_tb: filelist.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module acq_tb -o Vacq_tb

run: obj_dir/Vacq_tb
	./obj_dir/Vacq_tb | tee /dev/stderr | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: all run clean
